// ==== design/wb_pkg.sv ====
package wb_pkg;

    // classic wishbone, single transfer only
    localparam int ADR_W = 32;
    localparam int DAT_W = 32;
    localparam int SEL_W = DAT_W / 8; // one enable per byte lane

    // manager -> target, held stable from stb high until ack is seen
    typedef struct packed {
        logic [ADR_W-1:0] adr;  // byte address
        logic [DAT_W-1:0] dat;  // write data
        logic [SEL_W-1:0] sel;  // byte enables
        logic             we;   // 1 = write
        logic             stb;  // strobe, valid transfer
        logic             cyc;  // bus cycle in progress
    } wb_req_t;

    // target -> manager
    typedef struct packed {
        logic [DAT_W-1:0] dat;  // read data, only meaningful with ack
        logic             ack;  // one cycle per transfer
    } wb_rsp_t;

endpackage

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

    // managers sharing the one channel
    localparam int NUM_MANAGERS = 4;
    localparam int MGR_IDX_W    = $clog2(NUM_MANAGERS);

    // sram window, word addressed behind a byte bus
    localparam logic [31:0] SRAM_BASE  = 32'h0000_0000;
    localparam int          SRAM_WORDS = 256;                 // 1 KiB
    localparam int          SRAM_ADR_W = $clog2(SRAM_WORDS);
    localparam logic [31:0] SRAM_BYTES = 32'(SRAM_WORDS * 4); // window size

    // status register window
    localparam logic [31:0] REG_BASE  = 32'h0001_0000;
    localparam logic [31:0] REG_BYTES = 32'd64;
    localparam int          REG_OFS_W = $clog2(64);           // byte offset bits inside window

    typedef logic [REG_OFS_W-1:0] reg_ofs_t;

    localparam reg_ofs_t REG_ID_OFS      = 6'h00;
    localparam reg_ofs_t REG_SCRATCH_OFS = 6'h04;
    localparam reg_ofs_t REG_CNT_OFS     = 6'h08; // manager i counter at +4*i

    localparam logic [31:0] SOC_ID = 32'h5742_0001;

endpackage

// ==== design/wb_arbiter.sv ====
module wb_arbiter #(
    parameter int NUM_MANAGERS = soc_map_pkg::NUM_MANAGERS
) (
    input  logic             CLK,
    input  logic             nRST,

    input  wb_pkg::wb_req_t  mgr_req [NUM_MANAGERS], // one request per manager
    output wb_pkg::wb_rsp_t  mgr_rsp [NUM_MANAGERS], // only the owner sees the response

    output wb_pkg::wb_req_t  bus_req,                // to the decoder
    input  wb_pkg::wb_rsp_t  bus_rsp,                // from the decoder

    output logic [NUM_MANAGERS-1:0] grant            // one-hot, who is on the bus right now
);

    // one-hot state, bit 0 is idle, bit i+1 is manager i owning the bus
    logic [NUM_MANAGERS:0] state;
    logic [NUM_MANAGERS:0] next_state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= '0;
            state[0] <= 1'b1; // come out of reset idle
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;  // hold by default, covers back-pressure
        bus_req    = '0;
        grant      = '0;
        for (int m = 0; m < NUM_MANAGERS; m++) begin
            mgr_rsp[m] = '0; // non-owners see ack low and dat zero
        end

        if (state[0]) begin
            // idle: walk from the top down so the lowest index is the last to stick
            for (int m = NUM_MANAGERS - 1; m >= 0; m--) begin
                if (mgr_req[m].stb && mgr_req[m].cyc) begin
                    next_state        = '0;
                    next_state[m + 1] = 1'b1;  // take ownership at the next edge
                    bus_req           = mgr_req[m]; // mealy pass-through this cycle
                    grant             = '0;
                    grant[m]          = 1'b1;
                end
            end
            // no response is routed while idle, targets have nothing pending
        end else begin
            // owned: route request out and response back to the owner alone
            for (int m = 0; m < NUM_MANAGERS; m++) begin
                if (state[m + 1]) begin
                    bus_req    = mgr_req[m];
                    grant[m]   = 1'b1;
                    mgr_rsp[m] = bus_rsp;
                    if (bus_rsp.ack) begin
                        next_state    = '0;
                        next_state[0] = 1'b1; // release, next edge may start a new grant
                    end
                end
            end
        end
    end

    // note: an owner that drops cyc without an ack would hang the bus,
    // the managers here always wait for their ack before releasing

endmodule

// ==== design/wb_addr_decoder.sv ====
module wb_addr_decoder (
    input  logic            CLK,
    input  logic            nRST,

    input  wb_pkg::wb_req_t bus_req,  // granted cycle from the arbiter
    output wb_pkg::wb_rsp_t bus_rsp,

    output wb_pkg::wb_req_t sram_req,
    input  wb_pkg::wb_rsp_t sram_rsp,

    output wb_pkg::wb_req_t reg_req,
    input  wb_pkg::wb_rsp_t reg_rsp
);

    logic sram_hit;   // address inside the sram window
    logic reg_hit;    // address inside the register window
    logic unm_stb;    // live cycle that nobody claims
    logic unm_ack_q;  // ack from the internal responder

    // both windows are power-of-two sized and aligned, so a mask compare does
    assign sram_hit = (bus_req.adr & ~(soc_map_pkg::SRAM_BYTES - 32'd1))
                      == soc_map_pkg::SRAM_BASE;
    assign reg_hit  = (bus_req.adr & ~(soc_map_pkg::REG_BYTES - 32'd1))
                      == soc_map_pkg::REG_BASE;

    assign unm_stb  = bus_req.stb && bus_req.cyc && !sram_hit && !reg_hit;

    // address and data fan out, only the strobes are gated
    always_comb begin
        sram_req     = bus_req;
        sram_req.stb = bus_req.stb && sram_hit;
        sram_req.cyc = bus_req.cyc && sram_hit;

        reg_req      = bus_req;
        reg_req.stb  = bus_req.stb && reg_hit;
        reg_req.cyc  = bus_req.cyc && reg_hit;
    end

    // unmapped responder, acks one cycle later like a real target, writes dropped
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= unm_stb && !unm_ack_q; // never twice for one cycle
        end
    end

    // response mux follows the address, which the owner holds through its ack
    always_comb begin
        if (sram_hit) begin
            bus_rsp = sram_rsp;
        end else if (reg_hit) begin
            bus_rsp = reg_rsp;
        end else begin
            bus_rsp.dat = '0;        // unmapped reads return zero
            bus_rsp.ack = unm_ack_q;
        end
    end

endmodule

// ==== design/wb_sram.sv ====
module wb_sram (
    input  logic            CLK,
    input  logic            nRST,

    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp
);

    logic [wb_pkg::DAT_W-1:0]          mem [soc_map_pkg::SRAM_WORDS];
    logic [soc_map_pkg::SRAM_ADR_W-1:0] word_idx; // word address, byte lane bits dropped
    logic                               access;   // first cycle of a new transfer
    logic                               ack_q;
    logic [wb_pkg::DAT_W-1:0]          rdat_q;

    assign word_idx = req.adr[soc_map_pkg::SRAM_ADR_W+1:2];
    assign access   = req.stb && req.cyc && !ack_q; // second cycle is the ack cycle, ignore it

    // ack control
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access; // high for exactly one cycle
        end
    end

    // storage and read port
    always_ff @(posedge CLK) begin
        if (access) begin
            rdat_q <= mem[word_idx]; // old contents, reads never overlap a write
            if (req.we) begin
                for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                    if (req.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req.dat[8*b +: 8]; // byte lane merge
                    end
                end
            end
        end
    end

    assign rsp.dat = rdat_q;
    assign rsp.ack = ack_q;

endmodule

// ==== design/wb_status_regs.sv ====
module wb_status_regs (
    input  logic            CLK,
    input  logic            nRST,

    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp,

    input  logic [soc_map_pkg::NUM_MANAGERS-1:0] grant, // current owner, one-hot
    input  logic                                 grant_ack // ack on the shared bus, any target
);

    soc_map_pkg::reg_ofs_t               ofs;      // word aligned byte offset
    soc_map_pkg::reg_ofs_t               cnt_rel;  // offset relative to the first counter
    logic [soc_map_pkg::MGR_IDX_W-1:0]   cnt_sel;  // which counter is addressed
    logic                                cnt_hit;
    logic                                access;
    logic                                ack_q;
    logic [wb_pkg::DAT_W-1:0]            rd_data;
    logic [wb_pkg::DAT_W-1:0]            rdat_q;
    logic [wb_pkg::DAT_W-1:0]            scratch;
    logic [31:0]                         cnt [soc_map_pkg::NUM_MANAGERS]; // completed transfers

    assign ofs     = {req.adr[soc_map_pkg::REG_OFS_W-1:2], 2'b00};
    assign cnt_rel = ofs - soc_map_pkg::REG_CNT_OFS;
    assign cnt_sel = cnt_rel[soc_map_pkg::MGR_IDX_W+1:2];
    assign cnt_hit = (ofs >= soc_map_pkg::REG_CNT_OFS)
                     && (cnt_rel[soc_map_pkg::REG_OFS_W-1:2] < soc_map_pkg::NUM_MANAGERS);
    assign access  = req.stb && req.cyc && !ack_q;

    // read mux, unused offsets read as zero
    always_comb begin
        rd_data = '0;
        if (ofs == soc_map_pkg::REG_ID_OFS) begin
            rd_data = soc_map_pkg::SOC_ID;
        end else if (ofs == soc_map_pkg::REG_SCRATCH_OFS) begin
            rd_data = scratch;
        end else if (cnt_hit) begin
            rd_data = cnt[cnt_sel];
        end
    end

    // control, scratch and counters
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack_q   <= 1'b0;
            scratch <= '0;
            for (int i = 0; i < soc_map_pkg::NUM_MANAGERS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            ack_q <= access;
            // only scratch is writable, ID and counters just ack
            if (access && req.we && ofs == soc_map_pkg::REG_SCRATCH_OFS) begin
                for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                    if (req.sel[b]) scratch[8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
            // bus ack only rises while the owner holds stb, so ack plus grant marks a done transfer
            for (int i = 0; i < soc_map_pkg::NUM_MANAGERS; i++) begin
                if (grant_ack && grant[i]) cnt[i] <= cnt[i] + 32'd1;
            end
        end
    end

    // read data sampled on the request cycle
    always_ff @(posedge CLK) begin
        if (access) rdat_q <= rd_data;
    end

    assign rsp.dat = rdat_q;
    assign rsp.ack = ack_q;

endmodule

// ==== design/wb_shared_bus_top.sv ====
module wb_shared_bus_top (
    input  logic            CLK,
    input  logic            nRST,

    input  wb_pkg::wb_req_t mgr_req [soc_map_pkg::NUM_MANAGERS],
    output wb_pkg::wb_rsp_t mgr_rsp [soc_map_pkg::NUM_MANAGERS]
);

    wb_pkg::wb_req_t bus_req;   // arbiter -> decoder
    wb_pkg::wb_rsp_t bus_rsp;   // decoder -> arbiter
    wb_pkg::wb_req_t sram_req;
    wb_pkg::wb_rsp_t sram_rsp;
    wb_pkg::wb_req_t reg_req;
    wb_pkg::wb_rsp_t reg_rsp;
    logic [soc_map_pkg::NUM_MANAGERS-1:0] grant; // owner, feeds the counters

    // one channel, fixed priority
    wb_arbiter #(
        .NUM_MANAGERS (soc_map_pkg::NUM_MANAGERS)
    ) wb_arbiter_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .grant   (grant)
    );

    wb_addr_decoder wb_addr_decoder_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp)
    );

    wb_sram wb_sram_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (sram_req),
        .rsp  (sram_rsp)
    );

    // counters watch the bus level ack so every target is counted
    wb_status_regs wb_status_regs_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (reg_req),
        .rsp       (reg_rsp),
        .grant     (grant),
        .grant_ack (bus_rsp.ack)
    );

endmodule

// ==== verif/tb_wb_shared_bus.sv ====
module tb_wb_shared_bus;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NM          = soc_map_pkg::NUM_MANAGERS;
    localparam int ACK_TIMEOUT = 32; // cycles a manager waits for its ack
    localparam int SRAM_TRIES  = 16; // words touched by the sram test
    localparam int ID_OFS      = int'(soc_map_pkg::REG_ID_OFS);
    localparam int SCR_OFS     = int'(soc_map_pkg::REG_SCRATCH_OFS);
    localparam int CNT_OFS     = int'(soc_map_pkg::REG_CNT_OFS);

    logic            CLK;
    logic            nRST;
    wb_pkg::wb_req_t mgr_req [NM];
    wb_pkg::wb_rsp_t mgr_rsp [NM];

    logic [31:0]   lfsr;
    logic [31:0]   ref_mem [soc_map_pkg::SRAM_WORDS]; // expected sram contents
    logic [31:0]   ref_scratch;
    int            ref_cnt [NM];                      // acked transfers per manager
    int            ack_order [$];                     // manager index per ack, in time order
    int            value_errors;
    int            protocol_errors;
    int            timeouts;
    logic [NM-1:0] ack_vec;
    logic [NM-1:0] bus_grant;
    logic          arb_idle;

    wb_shared_bus_top wb_shared_bus_top_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always_comb begin
        for (int m = 0; m < NM; m++) begin
            ack_vec[m] = mgr_rsp[m].ack;
        end
    end
    assign bus_grant = wb_shared_bus_top_inst.grant;
    assign arb_idle  = wb_shared_bus_top_inst.wb_arbiter_inst.state[0]; // idle bit of the FSM

    // protocol checks on every edge out of reset
    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(ack_vec)) else begin
        protocol_errors++;
        $display("At %0t two managers were acknowledged in the same cycle", $time);
    end
    assert property (@(posedge CLK) disable iff (!nRST) (|ack_vec) |=> (ack_vec == '0)) else begin
        protocol_errors++;
        $display("At %0t an ack stayed high for more than one cycle", $time);
    end
    assert property (@(posedge CLK) disable iff (!nRST)
        (arb_idle && |bus_grant) |=> (ack_vec == $past(bus_grant))) else begin
        protocol_errors++;
        $display("At %0t the granted manager was not acked one cycle after its grant", $time);
    end
    assert property (@(posedge CLK) disable iff (!nRST) (ack_vec & ~bus_grant) == '0) else begin
        protocol_errors++;
        $display("At %0t a manager that does not own the bus saw an ack", $time);
    end
    assert property (@(posedge CLK) disable iff (!nRST)
        $onehot(wb_shared_bus_top_inst.wb_arbiter_inst.state)) else begin
        protocol_errors++;
        $display("At %0t the arbiter state is not one-hot", $time);
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // byte lanes with sel set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdat,
                                                input logic [3:0]  sel);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) r[8*b +: 8] = wdat[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_adr(input int ofs);
        return soc_map_pkg::REG_BASE + 32'(ofs);
    endfunction

    function automatic logic [31:0] sram_adr(input logic [7:0] idx);
        return soc_map_pkg::SRAM_BASE + (32'(idx) << 2); // word index to byte address
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            value_errors++;
            $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_quiet_responses();
        for (int m = 0; m < NM; m++) begin
            compare_word($sformatf("mgr_rsp[%0d].ack", m), '0, 32'(mgr_rsp[m].ack));
            compare_word($sformatf("mgr_rsp[%0d].dat", m), '0, mgr_rsp[m].dat);
        end
    endtask

    // one classic wishbone cycle from manager m
    task automatic bus_cycle(input int m, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we, output logic [31:0] rdat);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        rdat    = '0;
        @(posedge CLK);
        #1;
        mgr_req[m].adr = adr;
        mgr_req[m].dat = dat;
        mgr_req[m].sel = sel;
        mgr_req[m].we  = we;
        mgr_req[m].stb = 1'b1;
        mgr_req[m].cyc = 1'b1;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge CLK); // mid cycle, ack and dat are settled
            waited++;
            if (mgr_rsp[m].ack) begin
                got_ack = 1'b1;
                rdat    = mgr_rsp[m].dat;
            end
        end
        @(posedge CLK);
        #1;
        mgr_req[m] = '0; // drop stb in the cycle after the ack
        if (got_ack) begin
            ref_cnt[m]++;
            ack_order.push_back(m);
        end else begin
            timeouts++;
            $display("Manager %0d got no ack within %0d cycles for address %h", m, waited, adr);
        end
    endtask

    task automatic write_word(input int m, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] rdat_drop;
        bus_cycle(m, adr, dat, sel, 1'b1, rdat_drop);
    endtask

    task automatic read_word(input int m, input logic [31:0] adr, input logic [31:0] exp,
                             input string what);
        logic [31:0] rdat;
        bus_cycle(m, adr, '0, 4'hf, 1'b0, rdat);
        compare_word($sformatf("mgr_rsp[%0d].dat (%s at %h)", m, what, adr), exp, rdat);
    endtask

    task automatic sram_test();
        logic [7:0]  idx [SRAM_TRIES];
        logic [31:0] d;
        logic [31:0] r;
        logic [3:0]  sel;
        for (int k = 0; k < SRAM_TRIES; k++) begin
            r      = random_bits(8);
            idx[k] = r[7:0];
            d      = random_bits(32);
            r      = random_bits(2);
            write_word(int'(r[1:0]), sram_adr(idx[k]), d, 4'hf); // full word first
            ref_mem[idx[k]] = d;
        end
        for (int k = 0; k < SRAM_TRIES; k++) begin
            d   = random_bits(32);
            r   = random_bits(4);
            sel = r[3:0];
            r   = random_bits(2);
            write_word(int'(r[1:0]), sram_adr(idx[k]), d, sel);
            ref_mem[idx[k]] = merge_bytes(ref_mem[idx[k]], d, sel);
        end
        for (int k = SRAM_TRIES - 1; k >= 0; k--) begin
            r = random_bits(2);
            read_word(int'(r[1:0]), sram_adr(idx[k]), ref_mem[idx[k]], "sram word");
        end
    endtask

    task automatic reg_test();
        logic [31:0] d;
        logic [31:0] r;
        read_word(0, reg_adr(ID_OFS), soc_map_pkg::SOC_ID, "ID");
        d = random_bits(32);
        write_word(1, reg_adr(SCR_OFS), d, 4'hf);
        ref_scratch = d;
        for (int k = 0; k < 6; k++) begin
            d = random_bits(32);
            r = random_bits(4);
            write_word(k % NM, reg_adr(SCR_OFS), d, r[3:0]);
            ref_scratch = merge_bytes(ref_scratch, d, r[3:0]);
            read_word((k + 1) % NM, reg_adr(SCR_OFS), ref_scratch, "scratch");
        end
        // read-only words just ack a write
        write_word(2, reg_adr(ID_OFS), random_bits(32), 4'hf);
        read_word(3, reg_adr(ID_OFS), soc_map_pkg::SOC_ID, "ID after write");
        write_word(0, reg_adr(CNT_OFS + 4), 32'hffff_ffff, 4'hf);
        read_word(2, reg_adr(CNT_OFS + 4), ref_cnt[1], "counter 1 after write");
    endtask

    task automatic unmapped_test();
        logic [31:0] unm_adr [3];
        logic [31:0] d;
        unm_adr[0] = soc_map_pkg::SRAM_BASE + soc_map_pkg::SRAM_BYTES + 32'h4; // word 1 alias
        unm_adr[1] = soc_map_pkg::REG_BASE + 32'h44;                           // scratch alias
        unm_adr[2] = 32'h8000_0000;
        d = random_bits(32);
        write_word(2, sram_adr(8'd1), d, 4'hf);
        ref_mem[1] = d;
        for (int k = 0; k < 3; k++) begin
            write_word(k, unm_adr[k], random_bits(32), 4'hf);
            read_word(k + 1, unm_adr[k], '0, "unmapped");
        end
        read_word(3, sram_adr(8'd1), ref_mem[1], "sram word 1 after unmapped write");
        read_word(0, reg_adr(SCR_OFS), ref_scratch, "scratch after unmapped write");
    endtask

    task automatic priority_test();
        logic [31:0] rd [NM];
        ack_order.delete();
        fork // all four raise stb in the same idle cycle
            bus_cycle(3, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[3]);
            bus_cycle(1, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[1]);
            bus_cycle(0, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[0]);
            bus_cycle(2, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[2]);
        join
        for (int m = 0; m < NM; m++) begin
            compare_word($sformatf("mgr_rsp[%0d].dat (ID)", m), soc_map_pkg::SOC_ID, rd[m]);
        end
        assert (ack_order.size() == NM) else begin
            protocol_errors++;
            $display("Priority test saw %0d acks instead of %0d", ack_order.size(), NM);
        end
        for (int k = 0; k < ack_order.size(); k++) begin
            compare_word($sformatf("ack_order[%0d]", k), 32'(k), 32'(ack_order[k]));
        end
        // manager 0 arrives while 3 owns the bus and has to wait
        ack_order.delete();
        fork
            bus_cycle(3, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[3]);
            begin
                @(posedge CLK);
                bus_cycle(0, reg_adr(ID_OFS), '0, 4'hf, 1'b0, rd[0]);
            end
        join
        assert (ack_order.size() == 2 && ack_order[0] == 3 && ack_order[1] == 0) else begin
            protocol_errors++;
            $display("A manager that arrived during another's cycle was acked out of turn");
        end
    endtask

    task automatic counter_test();
        for (int i = 0; i < NM; i++) begin
            read_word((i + 1) % NM, reg_adr(CNT_OFS + 4 * i), ref_cnt[i],
                      $sformatf("counter %0d", i));
            read_word(i, reg_adr(CNT_OFS + 4 * i), ref_cnt[i],
                      $sformatf("counter %0d read by its own manager", i));
        end
    endtask

    initial begin
        nRST            = 1'b0;
        lfsr            = 32'hdf82_76be;
        ref_scratch     = '0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        for (int m = 0; m < NM; m++) begin
            mgr_req[m] = '0;
            ref_cnt[m] = 0;
        end
        for (int c = 0; c < 8; c++) begin
            @(negedge CLK);
            check_quiet_responses(); // held in reset
        end
        @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int c = 0; c < 2; c++) begin
            @(negedge CLK);
            check_quiet_responses(); // nothing requested yet
        end
        sram_test();
        reg_test();
        unmapped_test();
        priority_test();
        counter_test();
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // whole run limit
    initial begin
        #200_000;
        $display("Simulation stopped because the run did not finish within 200 us");
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== project.f ====
design/wb_pkg.sv
design/soc_map_pkg.sv
design/wb_arbiter.sv
design/wb_addr_decoder.sv
design/wb_sram.sv
design/wb_status_regs.sv
design/wb_shared_bus_top.sv
verif/tb_wb_shared_bus.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the shared bus testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_wb_shared_bus
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module "$TOP" -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qF '*** FAILED ***' "$LOG"
rc=$?
if [ $rc -eq 0 ]; then
    echo "simulation reported a failure, see $LOG"
    exit 1
elif [ $rc -ne 1 ]; then
    echo "could not search $LOG"
    exit 1
fi
exit 0
